/* rtl/apb_map_pkg.sv */
package apb_map_pkg;

   typedef logic [7:0]  apb_addr_t;   // register byte address
   typedef logic [31:0] apb_data_t;   // bus data

   ////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////
   localparam apb_addr_t addr_ctrl    = 8'h00;  // write only, command bits
   localparam apb_addr_t addr_song    = 8'h04;  // song number and record mode
   localparam apb_addr_t addr_volume  = 8'h08;
   localparam apb_addr_t addr_limit   = 8'h0C;  // hard limiter setup
   localparam apb_addr_t addr_status  = 8'h10;  // read only
   localparam apb_addr_t addr_address = 8'h14;  // read only, memory address

   // ctrl command bits
   localparam int ctrl_start_bit = 0;
   localparam int ctrl_pause_bit = 1;   // toggles
   localparam int ctrl_stop_bit  = 2;

   // field positions
   localparam int song_record_bit    = 4;
   localparam int limit_enable_bit   = 2;
   localparam int status_paused_bit  = 2;
   localparam int status_done_bit    = 3;  // sticky, start clears it
   localparam int status_seconds_lsb = 8;

endpackage

/* rtl/player_pkg.sv */
package player_pkg;

   ////////////////////////////////////////////////////////////
   // audio and player types
   ////////////////////////////////////////////////////////////
   typedef logic signed [11:0] sample_t;   // codec sample, two's complement
   typedef logic [4:0]  volume_t;
   typedef logic [3:0]  song_t;
   typedef logic [7:0]  seconds_t;
   typedef logic [18:0] mem_addr_t;        // zbt word address
   typedef logic [1:0]  limit_t;

   // central player fsm
   typedef enum logic [1:0] {
      standby  = 2'd0,
      playback = 2'd1,
      record   = 2'd2
   } player_state_t;

   ////////////////////////////////////////////////////////////
   // constants
   ////////////////////////////////////////////////////////////
   localparam volume_t volume_reset = 5'd8;   // unity gain
   localparam int volume_shift = 3;           // gain is volume / 8

   localparam int song_words_default        = 32768;
   localparam int cycles_per_second_default = 27_000_000;
   localparam int codec_reset_cycles        = 1023;

   // 12 bit full scale
   localparam sample_t sample_max = 12'sd2047;
   localparam sample_t sample_min = -12'sd2048;

   // hard limiter clip levels, by limiter amount
   localparam sample_t limit_threshold [0:3] = '{12'sd1023, 12'sd511, 12'sd255, 12'sd127};

endpackage

/* rtl/player_ctrl.sv */
`timescale 1ns/1ps

module player_ctrl (
   input  logic                      clock_27mhz,
   input  logic                      reset,
   // apb slave
   input  apb_map_pkg::apb_addr_t    paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  apb_map_pkg::apb_data_t    pwdata,
   output apb_map_pkg::apb_data_t    prdata,
   output logic                      pready,
   output logic                      pslverr,
   // back from the datapath
   input  logic                      song_done,
   input  player_pkg::seconds_t      seconds,
   input  player_pkg::mem_addr_t     mem_address,
   // player controls
   output player_pkg::player_state_t state,
   output logic                      paused,
   output logic                      start_pulse,
   output player_pkg::song_t         song,
   output player_pkg::volume_t       volume,
   output player_pkg::limit_t        limit_amount,
   output logic                      limit_enable
);
   import apb_map_pkg::*;
   import player_pkg::*;

   logic access;         // apb access phase
   logic addr_known;
   logic addr_readonly;
   logic wr_ok;          // write that lands
   logic cmd_start;
   logic cmd_pause;
   logic cmd_stop;
   logic record_mode;
   logic done_flag;      // sticky song done

   ////////////////////////////////////////////////////////////
   // apb decode
   ////////////////////////////////////////////////////////////
   assign pready = 1'b1;              // zero wait states
   assign access = psel & penable;

   always_comb begin
      addr_known    = 1'b1;
      addr_readonly = 1'b0;
      case (paddr)
         addr_ctrl, addr_song, addr_volume, addr_limit: addr_readonly = 1'b0;
         addr_status, addr_address:                     addr_readonly = 1'b1;
         default:                                       addr_known = 1'b0;
      endcase
   end

   // song may only change while stopped
   assign pslverr = access & (~addr_known | (pwrite & addr_readonly) |
                    (pwrite & (paddr == addr_song) & (state != standby)));
   assign wr_ok   = access & pwrite & ~pslverr;

   assign cmd_start = wr_ok & (paddr == addr_ctrl) & pwdata[ctrl_start_bit];
   assign cmd_pause = wr_ok & (paddr == addr_ctrl) & pwdata[ctrl_pause_bit];
   assign cmd_stop  = wr_ok & (paddr == addr_ctrl) & pwdata[ctrl_stop_bit];

   // register file
   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         song         <= '0;
         record_mode  <= 1'b0;
         volume       <= volume_reset;
         limit_amount <= '0;
         limit_enable <= 1'b0;
      end else if (wr_ok) begin
         case (paddr)
            addr_song: begin
               song        <= song_t'(pwdata);
               record_mode <= pwdata[song_record_bit];
            end
            addr_volume: volume <= volume_t'(pwdata);
            addr_limit: begin
               limit_amount <= limit_t'(pwdata);
               limit_enable <= pwdata[limit_enable_bit];
            end
            default: ;   // ctrl is command only
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // central fsm
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         start_pulse <= 1'b0;
         state       <= standby;
         paused      <= 1'b0;
         done_flag   <= 1'b0;
      end else begin
         start_pulse <= cmd_start & (state == standby);  // ignored while running
         if (cmd_stop || song_done) begin
            state  <= standby;
            paused <= 1'b0;
         end else if (start_pulse) begin
            state  <= record_mode ? record : playback;
            paused <= 1'b0;
         end else if (cmd_pause && state != standby) begin
            paused <= ~paused;
         end
         if (song_done) done_flag <= 1'b1;
         else if (start_pulse) done_flag <= 1'b0;
      end
   end

   // read mux, unused bits stay zero
   always_comb begin
      prdata = '0;
      case (paddr)
         addr_song: begin
            prdata[3:0]             = song;
            prdata[song_record_bit] = record_mode;
         end
         addr_volume: prdata[4:0] = volume;
         addr_limit: begin
            prdata[1:0]              = limit_amount;
            prdata[limit_enable_bit] = limit_enable;
         end
         addr_status: begin
            prdata[1:0]                        = state;
            prdata[status_paused_bit]          = paused;
            prdata[status_done_bit]            = done_flag;
            prdata[status_seconds_lsb +: 8]    = seconds;
         end
         addr_address: prdata[18:0] = mem_address;
         default: ;
      endcase
   end

   a_state_legal: assert property (@(posedge clock_27mhz) disable iff (reset)
      state inside {standby, playback, record});

endmodule

/* rtl/codec_sync.sv */
`timescale 1ns/1ps

module codec_sync (
   input  logic clock_27mhz,
   input  logic reset,
   input  logic codec_ready,     // async, from codec clock domain
   output logic sample_strobe,
   output logic audio_reset_b
);
   import player_pkg::*;

   localparam int delay_w = $clog2(codec_reset_cycles + 1);

   logic [2:0]         ready_sync;    // two sync flops plus edge history
   logic [delay_w-1:0] delay_count;

   ////////////////////////////////////////////////////////////
   // ready synchronizer and edge detect
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock_27mhz) begin
      if (reset) ready_sync <= '0;
      else ready_sync <= {ready_sync[1:0], codec_ready};
   end

   // one pulse per rising edge
   assign sample_strobe = ready_sync[1] & ~ready_sync[2];

   // hold codec in reset a while after power up
   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         delay_count   <= '0;
         audio_reset_b <= 1'b0;
      end else if (delay_count == delay_w'(codec_reset_cycles)) begin
         audio_reset_b <= 1'b1;    // counter parks here
      end else begin
         delay_count <= delay_count + 1'b1;
      end
   end

   a_strobe_single: assert property (@(posedge clock_27mhz) disable iff (reset)
      sample_strobe |=> !sample_strobe);

endmodule

/* rtl/song_timer.sv */
`timescale 1ns/1ps

module song_timer #(
   parameter int cycles_per_second = player_pkg::cycles_per_second_default
) (
   input  logic                      clock_27mhz,
   input  logic                      reset,
   input  logic                      start_pulse,
   input  player_pkg::player_state_t state,
   input  logic                      paused,
   output player_pkg::seconds_t      seconds
);
   import player_pkg::*;

   localparam int tick_w = $clog2(cycles_per_second + 1);
   localparam logic [tick_w-1:0] tick_last = tick_w'(cycles_per_second - 1);

   logic [tick_w-1:0] tick_count;   // cycles into the current second
   logic              running;

   assign running = (state != standby) & ~paused;

   ////////////////////////////////////////////////////////////
   // elapsed time
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock_27mhz) begin
      if (reset || start_pulse) begin
         tick_count <= '0;
         seconds    <= '0;
      end else if (running) begin
         if (tick_count == tick_last) begin
            tick_count <= '0;
            if (~&seconds) seconds <= seconds + 1'b1;   // stick at 255
         end else begin
            tick_count <= tick_count + 1'b1;
         end
      end
   end

endmodule

/* rtl/song_address.sv */
`timescale 1ns/1ps

module song_address #(
   parameter int song_words = player_pkg::song_words_default
) (
   input  logic                      clock_27mhz,
   input  logic                      reset,
   input  logic                      start_pulse,
   input  player_pkg::player_state_t state,
   input  logic                      paused,
   input  player_pkg::song_t         song,
   input  logic                      sample_strobe,
   output player_pkg::mem_addr_t     mem_address,
   output logic                      mem_we,
   output logic                      song_done
);
   import player_pkg::*;

   localparam int offset_w = (song_words > 1) ? $clog2(song_words) : 1;
   localparam logic [offset_w-1:0] offset_last = offset_w'(song_words - 1);

   logic [offset_w-1:0] offset;      // word within the song
   logic                running;
   logic                advance;     // strobe that moves the address
   mem_addr_t           song_base;

   assign running = (state != standby) & ~paused;
   assign advance = sample_strobe & running;

   ////////////////////////////////////////////////////////////
   // address generation
   ////////////////////////////////////////////////////////////
   assign song_base   = mem_addr_t'(song) * mem_addr_t'(song_words);
   assign mem_address = song_base + mem_addr_t'(offset);

   // record writes the live sample, a paused recorder writes nothing
   assign mem_we    = advance & (state == record);
   assign song_done = advance & (offset == offset_last);

   always_ff @(posedge clock_27mhz) begin
      if (reset || start_pulse) begin
         offset <= '0;
      end else if (advance) begin
         if (offset == offset_last) offset <= '0;  // wrap, fsm stops us
         else offset <= offset + 1'b1;
      end
   end

   a_offset_range: assert property (@(posedge clock_27mhz) disable iff (reset)
      offset < song_words);

endmodule

/* rtl/sample_shaper.sv */
`timescale 1ns/1ps

module sample_shaper (
   input  logic                      clock_27mhz,
   input  logic                      reset,
   input  logic                      sample_strobe,
   input  player_pkg::player_state_t state,
   input  player_pkg::sample_t       mem_read_data,
   input  player_pkg::sample_t       codec_in,
   input  player_pkg::volume_t       volume,
   input  player_pkg::limit_t        limit_amount,
   input  logic                      limit_enable,
   output player_pkg::sample_t       sample_out
);
   import player_pkg::*;

   sample_t            source;
   logic signed [17:0] gain_product;   // 12 bit sample times 6 bit signed gain
   logic signed [17:0] gain_scaled;
   sample_t            saturated;
   sample_t            threshold;
   sample_t            limited;

   // memory in playback, live input otherwise
   assign source = (state == playback) ? mem_read_data : codec_in;

   ////////////////////////////////////////////////////////////
   // gain, saturation, limiter
   ////////////////////////////////////////////////////////////
   assign gain_product = source * $signed({1'b0, volume});
   assign gain_scaled  = gain_product >>> volume_shift;

   always_comb begin
      if (gain_scaled > sample_max) saturated = sample_max;
      else if (gain_scaled < sample_min) saturated = sample_min;
      else saturated = sample_t'(gain_scaled);
   end

   assign threshold = limit_threshold[limit_amount];

   always_comb begin
      limited = saturated;
      if (limit_enable) begin
         if (saturated > threshold) limited = threshold;
         else if (saturated < -threshold) limited = -threshold;   // symmetric clip
      end
   end

   // new sample once per strobe
   always_ff @(posedge clock_27mhz) begin
      if (reset) sample_out <= '0;
      else if (sample_strobe) sample_out <= limited;
   end

endmodule

/* rtl/music_core_top.sv */
`timescale 1ns/1ps

module music_core_top #(
   parameter int song_words        = player_pkg::song_words_default,
   parameter int cycles_per_second = player_pkg::cycles_per_second_default
) (
   input  logic                   clock_27mhz,
   input  logic                   reset,
   // apb slave
   input  apb_map_pkg::apb_addr_t paddr,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  apb_map_pkg::apb_data_t pwdata,
   output apb_map_pkg::apb_data_t prdata,
   output logic                   pready,
   output logic                   pslverr,
   // codec side
   input  logic                   codec_ready,
   input  player_pkg::sample_t    codec_in,
   output logic                   audio_reset_b,
   output player_pkg::sample_t    sample_out,
   // sample memory
   input  player_pkg::sample_t    mem_read_data,
   output player_pkg::mem_addr_t  mem_address,
   output logic                   mem_we,
   output player_pkg::sample_t    mem_write_data
);
   import player_pkg::*;

   player_state_t state;
   logic          paused;
   logic          start_pulse;
   song_t         song;
   volume_t       volume;
   limit_t        limit_amount;
   logic          limit_enable;
   logic          sample_strobe;   // one per codec sample
   logic          song_done;
   seconds_t      seconds;

   // recording stores the raw codec sample
   assign mem_write_data = codec_in;

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////
   player_ctrl i_player_ctrl (
      .clock_27mhz  (clock_27mhz),
      .reset        (reset),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .song_done    (song_done),
      .seconds      (seconds),
      .mem_address  (mem_address),
      .state        (state),
      .paused       (paused),
      .start_pulse  (start_pulse),
      .song         (song),
      .volume       (volume),
      .limit_amount (limit_amount),
      .limit_enable (limit_enable)
   );

   ////////////////////////////////////////////////////////////
   // datapath
   ////////////////////////////////////////////////////////////
   codec_sync i_codec_sync (
      .clock_27mhz   (clock_27mhz),
      .reset         (reset),
      .codec_ready   (codec_ready),
      .sample_strobe (sample_strobe),
      .audio_reset_b (audio_reset_b)
   );

   song_timer #(.cycles_per_second(cycles_per_second)) i_song_timer (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .start_pulse (start_pulse),
      .state       (state),
      .paused      (paused),
      .seconds     (seconds)
   );

   song_address #(.song_words(song_words)) i_song_address (
      .clock_27mhz   (clock_27mhz),
      .reset         (reset),
      .start_pulse   (start_pulse),
      .state         (state),
      .paused        (paused),
      .song          (song),
      .sample_strobe (sample_strobe),
      .mem_address   (mem_address),
      .mem_we        (mem_we),
      .song_done     (song_done)
   );

   sample_shaper i_sample_shaper (
      .clock_27mhz   (clock_27mhz),
      .reset         (reset),
      .sample_strobe (sample_strobe),
      .state         (state),
      .mem_read_data (mem_read_data),
      .codec_in      (codec_in),
      .volume        (volume),
      .limit_amount  (limit_amount),
      .limit_enable  (limit_enable),
      .sample_out    (sample_out)
   );

endmodule

/* sim/tb_music_core.sv */
`timescale 1ns/1ps

module tb_music_core;
   import apb_map_pkg::*;
   import player_pkg::*;

   localparam int song_words_tb  = 64;
   localparam int cycles_per_sec = 100;
   localparam int timeout_cycles = 20000;   // roughly 4x the summed tests

   logic      clock_27mhz = 1'b0;
   logic      reset;
   apb_addr_t paddr;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;
   logic      codec_ready;
   sample_t   codec_in;
   sample_t   mem_read_data;
   logic      audio_reset_b;
   sample_t   sample_out;
   mem_addr_t mem_address;
   logic      mem_we;
   sample_t   mem_write_data;

   int cycle_count = 0;
   int error_count = 0;
   int test_start_errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int we_count = 0;        // mem_we pulses seen
   int exp_sample = 0;

   // player model
   int m_state = 0;         // 0 standby, 1 playback, 2 record
   int m_paused = 0;
   int m_offset = 0;
   int m_done = 0;
   int m_song = 0;
   int m_record = 0;
   int m_volume = 8;
   int m_limit = 0;         // bit 2 enable, bits 1:0 amount

   music_core_top #(
      .song_words        (song_words_tb),
      .cycles_per_second (cycles_per_sec)
   ) i_music_core_top (
      .clock_27mhz    (clock_27mhz),
      .reset          (reset),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .codec_ready    (codec_ready),
      .codec_in       (codec_in),
      .audio_reset_b  (audio_reset_b),
      .sample_out     (sample_out),
      .mem_read_data  (mem_read_data),
      .mem_address    (mem_address),
      .mem_we         (mem_we),
      .mem_write_data (mem_write_data)
   );

   initial begin
      forever #50 clock_27mhz = ~clock_27mhz;   // 100 ns period
   end

   always @(posedge clock_27mhz) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // record writes, sampled mid low phase
   always @(negedge clock_27mhz) begin
      #25;
      if (mem_we === 1'b1) begin
         we_count = we_count + 1;
         compare_value("mem_write_data", mem_write_data, codec_in);
      end
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   task automatic compare_value(input string name, input logic signed [31:0] actual,
                                input logic signed [31:0] expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
         error_count = error_count + 1;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run = tests_run + 1;
      if (error_count == test_start_errors) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %0d %s: failed, %0d errors", tests_run, name,
                  error_count - test_start_errors);
      end
      test_start_errors = error_count;
   endtask

   // setup cycle, access cycle, then idle
   task automatic bus_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      @(negedge clock_27mhz);
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clock_27mhz);
      penable = 1'b1;
      #10;
      err = pslverr;
      compare_value("pready", pready, 1);
      @(negedge clock_27mhz);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic bus_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      @(negedge clock_27mhz);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clock_27mhz);
      penable = 1'b1;
      #10;
      data = prdata;   // valid in the access cycle
      err  = pslverr;
      @(negedge clock_27mhz);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // gain of volume/8, 12 bit saturation, then the hard limiter
   function automatic int shape(input int source);
      int level;
      int clip;
      level = (source * m_volume) >>> 3;   // floor, like an arithmetic shift
      if (level > 2047) level = 2047;
      if (level < -2048) level = -2048;
      clip = 1023 >> (m_limit % 4);        // 1023, 511, 255, 127
      if (((m_limit >> 2) & 1) == 1) begin
         if (level > clip) level = clip;
         if (level < -clip) level = -clip;
      end
      return level;
   endfunction

   // one codec sample: rising edge, random high and low phases
   task automatic play_sample();
      int high_cycles;
      int low_cycles;
      high_cycles = 4 + $urandom % 9;
      low_cycles  = 4 + $urandom % 9;
      @(negedge clock_27mhz);
      codec_ready   = 1'b1;
      codec_in      = sample_t'($urandom);
      mem_read_data = sample_t'($urandom);
      exp_sample = shape((m_state == 1) ? mem_read_data : codec_in);
      if (m_state != 0 && m_paused == 0) begin
         if (m_offset == song_words_tb - 1) begin
            m_offset = 0;   // last word ends the song
            m_state  = 0;
            m_done   = 1;
         end else begin
            m_offset = m_offset + 1;
         end
      end
      repeat (high_cycles) @(negedge clock_27mhz);
      codec_ready = 1'b0;
      repeat (low_cycles) @(negedge clock_27mhz);
      #25;   // strobe long done, 3 cycle tolerance covered
      compare_value("sample_out", sample_out, exp_sample);
      compare_value("mem_address", mem_address, m_song * song_words_tb + m_offset);
   endtask

   task automatic start_player();
      logic err;
      bus_write(addr_ctrl, 32'h1, err);
      compare_value("pslverr on start", err, 0);
      @(negedge clock_27mhz);   // state moves one cycle after start_pulse
      m_state  = (m_record == 1) ? 2 : 1;
      m_paused = 0;
      m_offset = 0;
      m_done   = 0;
   endtask

   task automatic stop_player();
      logic err;
      bus_write(addr_ctrl, 32'h4, err);
      m_state  = 0;
      m_paused = 0;
   endtask

   task automatic check_status();
      apb_data_t rdata;
      logic      err;
      bus_read(addr_status, rdata, err);
      compare_value("status state", rdata[1:0], m_state);
      compare_value("status paused", rdata[2], m_paused);
      compare_value("status done", rdata[3], m_done);
   endtask

   task automatic check_registers();
      apb_data_t rdata;
      logic      err;
      bus_read(addr_song, rdata, err);
      compare_value("song register", rdata, m_song + 16 * m_record);
      bus_read(addr_volume, rdata, err);
      compare_value("volume register", rdata, m_volume);
      bus_read(addr_limit, rdata, err);
      compare_value("limit register", rdata, m_limit);
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int        i;
      int        n;
      int        sel;
      int        mode;
      int        reset_release;
      int        seen;
      apb_addr_t addr;
      apb_data_t data;
      apb_data_t rdata;
      logic      err;
      void'($urandom(32'hbdf3));
      reset         = 1'b1;
      paddr         = '0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      pwdata        = '0;
      codec_ready   = 1'b0;
      codec_in      = '0;
      mem_read_data = '0;
      repeat (2) @(negedge clock_27mhz);
      reset = 1'b0;
      reset_release = cycle_count;

      // 1: reset values and codec reset delay
      compare_value("mem_we", mem_we, 0);
      compare_value("pslverr", pslverr, 0);
      compare_value("sample_out", sample_out, 0);
      compare_value("audio_reset_b", audio_reset_b, 0);
      check_registers();
      check_status();
      bus_read(addr_address, rdata, err);
      compare_value("address register", rdata, 0);
      while (cycle_count - reset_release < 1000) @(negedge clock_27mhz);
      compare_value("audio_reset_b", audio_reset_b, 0);
      while (cycle_count - reset_release < 1030) @(negedge clock_27mhz);
      compare_value("audio_reset_b", audio_reset_b, 1);
      finish_test("reset and codec reset");

      // 2: register read back and bus errors
      for (i = 0; i < 24; i++) begin
         sel  = $urandom % 3;
         data = $urandom;
         addr = (sel == 0) ? addr_song : (sel == 1) ? addr_volume : addr_limit;
         bus_write(addr, data, err);
         compare_value("pslverr", err, 0);
         if (sel == 0) begin
            m_song   = data % 16;
            m_record = (data >> 4) & 1;
         end else if (sel == 1) begin
            m_volume = data % 32;
         end else begin
            m_limit = data % 8;
         end
         check_registers();
      end
      repeat (4) begin
         addr = apb_addr_t'(8'h15 + $urandom % 235);   // past the map
         bus_write(addr, $urandom, err);
         compare_value("pslverr unmapped write", err, 1);
         bus_read(addr, rdata, err);
         compare_value("pslverr unmapped read", err, 1);
      end
      bus_write(addr_status, 32'hffff_ffff, err);
      compare_value("pslverr status write", err, 1);
      bus_write(addr_address, 32'hffff_ffff, err);
      compare_value("pslverr address write", err, 1);
      start_player();
      bus_write(addr_song, $urandom, err);
      compare_value("pslverr song write while running", err, 1);
      stop_player();
      check_registers();
      check_status();
      finish_test("apb registers");

      // 3: playback addresses, pause and end of song
      we_count = 0;
      m_song   = $urandom % 16;
      m_record = 0;
      bus_write(addr_song, m_song, err);
      start_player();
      compare_value("mem_address", mem_address, m_song * song_words_tb);
      check_status();
      for (i = 0; i < song_words_tb; i++) begin
         if (i == 20) begin
            bus_write(addr_ctrl, 32'h2, err);
            m_paused = 1;
            check_status();
            repeat (3) play_sample();   // address holds
            bus_write(addr_ctrl, 32'h2, err);
            m_paused = 0;
            check_status();
         end
         play_sample();
      end
      check_status();   // standby, done set
      compare_value("mem_we pulses in playback", we_count, 0);
      finish_test("playback addresses");

      // 4: recording
      we_count = 0;
      m_song   = $urandom % 16;
      m_record = 1;
      bus_write(addr_song, m_song + 16, err);
      start_player();
      repeat (10) play_sample();
      compare_value("mem_we pulses", we_count, 10);
      check_status();
      stop_player();
      check_status();
      compare_value("mem_we pulses after stop", we_count, 10);
      finish_test("recording");

      // 5: shaping in standby, playback and record
      for (mode = 0; mode < 3; mode++) begin
         if (mode > 0) begin
            m_song   = $urandom % 16;
            m_record = (mode == 2) ? 1 : 0;
            bus_write(addr_song, m_song + 16 * m_record, err);
            start_player();
         end
         repeat (8) begin
            data = $urandom;
            bus_write(addr_volume, data, err);
            m_volume = data % 32;
            data = $urandom;
            bus_write(addr_limit, data, err);
            m_limit = data % 8;
            play_sample();
         end
         if (mode > 0) stop_player();
      end
      finish_test("sample shaping");

      // 6: elapsed seconds
      n = 2 + $urandom % 3;
      m_record = 0;
      bus_write(addr_song, m_song, err);
      start_player();
      repeat (n * cycles_per_sec) @(negedge clock_27mhz);
      bus_read(addr_status, rdata, err);
      seen = rdata[15:8];
      // within one second either way counts as a match
      compare_value("status seconds within one of expected",
                    (seen >= n - 1 && seen <= n + 1), 1);
      stop_player();
      start_player();
      bus_read(addr_status, rdata, err);
      compare_value("status seconds after start", rdata[15:8], 0);
      stop_player();
      finish_test("song seconds");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* files.f */
rtl/apb_map_pkg.sv
rtl/player_pkg.sv
rtl/player_ctrl.sv
rtl/codec_sync.sv
rtl/song_timer.sv
rtl/song_address.sv
rtl/sample_shaper.sv
rtl/music_core_top.sv
sim/tb_music_core.sv
